// File: src/vend_pkg.sv
/*
 * Shared definitions for the vending machine controller.
 * Holds the money and coin widths, the coin and price tables, the bundled
 * keypad and request types and the controller state encoding.
 * Design files refer to everything here by scoped name.
 */
`default_nettype none

package vend_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and sizes
    //////////////////////////////////////////////////////////////////////

    localparam int CENTS_W   = 10;                 // Every money value
    localparam int COIN_W    = 3;                  // Coin code, 0 is no coin
    localparam int ITEM_W    = 5;                  // Item code, 0 is no item
    localparam int NUM_ROWS  = 4;                  // Rows A to D
    localparam int NUM_COLS  = 5;
    localparam int NUM_COINS = 6;
    localparam int ROW_IDX_W = $clog2(NUM_ROWS);
    localparam int COL_IDX_W = $clog2(NUM_COLS);

    //////////////////////////////////////////////////////////////////////
    // Tables
    //////////////////////////////////////////////////////////////////////

    // Cents per coin code, kept in ascending order for the greedy change pick
    localparam logic [CENTS_W-1:0] COIN_VALUE [1:NUM_COINS] = '{
        10'd1, 10'd5, 10'd10, 10'd25, 10'd50, 10'd100
    };

    localparam logic [CENTS_W-1:0] ROW_PRICE [0:NUM_ROWS-1] = '{
        10'd100, 10'd125, 10'd150, 10'd175
    };

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [NUM_ROWS-1:0] row;                  // Bit 0 is row A
        logic [NUM_COLS-1:0] col;                  // Bit 0 is column 1
    } keypad_t;

    typedef struct packed {
        logic               valid;
        logic [ITEM_W-1:0]  item;
        logic [CENTS_W-1:0] price;
    } vend_request_t;

    typedef enum logic [1:0] {
        COLLECTING = 2'd0,
        VENDING    = 2'd1,
        RETURNING  = 2'd2
    } vend_state_t;

endpackage

`default_nettype wire

// File: src/coin_accumulator.sv
/*
 * Credit register of the vending machine.
 * Each coin code offered while coin_enable is high adds its value at the
 * next clock edge. The sum saturates at full scale, and credit_clear
 * empties the register ahead of any coin in the same cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module coin_accumulator (
    input  wire                            clock,
    input  wire                            reset,
    input  wire  [vend_pkg::COIN_W-1:0]    coin,
    input  wire                            coin_enable,
    input  wire                            credit_clear,
    output logic [vend_pkg::CENTS_W-1:0]   credit
);

    logic [vend_pkg::CENTS_W-1:0] coin_value;
    logic [vend_pkg::CENTS_W:0]   sum;         // One extra bit for overflow

    always_comb begin
        coin_value = '0;                        // Codes 0 and 7 add nothing
        for (int i = 1; i <= vend_pkg::NUM_COINS; i++) begin
            if (coin == i[vend_pkg::COIN_W-1:0]) begin
                coin_value = vend_pkg::COIN_VALUE[i];
            end
        end
    end

    assign sum = {1'b0, credit} + {1'b0, coin_value};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            credit <= '0;
        end else if (credit_clear) begin
            credit <= '0;
        end else if (coin_enable) begin
            if (sum[vend_pkg::CENTS_W]) begin
                credit <= '1;                   // Saturate
            end else begin
                credit <= sum[vend_pkg::CENTS_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/keypad_decoder.sv
/*
 * Combinational keypad decoder.
 * A request is valid only when exactly one row button and one column
 * button are down. The item code is row * 5 + column + 1 with row A and
 * column 1 counted as zero, and the price comes from the row's tier.
 */
`timescale 1ns/1ps
`default_nettype none

module keypad_decoder (
    input  wire  vend_pkg::keypad_t        keypad,
    output vend_pkg::vend_request_t        request
);

    logic [vend_pkg::ROW_IDX_W-1:0] row_idx;
    logic [vend_pkg::COL_IDX_W-1:0] col_idx;
    logic                           valid;
    int unsigned                    item_num;

    // Position of the pressed buttons, only meaningful when one-hot
    always_comb begin
        row_idx = '0;
        col_idx = '0;
        for (int r = 0; r < vend_pkg::NUM_ROWS; r++) begin
            if (keypad.row[r]) begin
                row_idx = r[vend_pkg::ROW_IDX_W-1:0];
            end
        end
        for (int c = 0; c < vend_pkg::NUM_COLS; c++) begin
            if (keypad.col[c]) begin
                col_idx = c[vend_pkg::COL_IDX_W-1:0];
            end
        end
    end

    assign valid    = $onehot(keypad.row) && $onehot(keypad.col);
    assign item_num = int'(row_idx) * vend_pkg::NUM_COLS + int'(col_idx) + 1;

    always_comb begin
        request = '0;
        if (valid) begin
            request.valid = 1'b1;
            request.item  = item_num[vend_pkg::ITEM_W-1:0];
            request.price = vend_pkg::ROW_PRICE[row_idx];
        end
    end

endmodule

`default_nettype wire

// File: src/vend_controller.sv
/*
 * Vending machine FSM.
 * COLLECTING takes coins and accepts a keypad request the credit covers.
 * VENDING holds the item code until the pressure sensor reports the drop.
 * RETURNING clears the credit, hands credit minus price to the change
 * dispenser and waits for it to finish.
 */
`timescale 1ns/1ps
`default_nettype none

module vend_controller (
    input  wire                              clock,
    input  wire                              reset,
    input  wire  vend_pkg::vend_request_t    request,
    input  wire  [vend_pkg::CENTS_W-1:0]     credit,
    input  wire                              food_dispensed,
    input  wire                              change_done,
    output logic                             coin_enable,
    output logic                             credit_clear,
    output logic                             change_load,
    output logic [vend_pkg::CENTS_W-1:0]     change_amount,
    output logic [vend_pkg::ITEM_W-1:0]      food_selection
);

    vend_pkg::vend_state_t        state;
    logic [vend_pkg::CENTS_W-1:0] price;
    logic                         accept;
    logic                         dispensed;

    //////////////////////////////////////////////////////////////////////
    // Decisions
    //////////////////////////////////////////////////////////////////////

    // The only credit check in the design
    assign accept = (state == vend_pkg::COLLECTING) && request.valid
                    && (request.price <= credit);

    assign dispensed   = (state == vend_pkg::VENDING) && food_dispensed;
    assign coin_enable = (state == vend_pkg::COLLECTING);

    //////////////////////////////////////////////////////////////////////
    // State and strobes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state          <= vend_pkg::COLLECTING;
            food_selection <= '0;
            credit_clear   <= 1'b0;
            change_load    <= 1'b0;
        end else begin
            credit_clear <= dispensed;          // One-cycle pulses
            change_load  <= dispensed;
            case (state)
                vend_pkg::COLLECTING: begin
                    if (accept) begin
                        state          <= vend_pkg::VENDING;
                        food_selection <= request.item;
                    end
                end
                vend_pkg::VENDING: begin
                    if (food_dispensed) begin
                        state          <= vend_pkg::RETURNING;
                        food_selection <= '0;
                    end
                end
                vend_pkg::RETURNING: begin
                    if (change_done) begin
                        state <= vend_pkg::COLLECTING;
                    end
                end
                default: begin
                    state <= vend_pkg::COLLECTING;
                end
            endcase
        end
    end

    // Credit is frozen during VENDING, so it already holds any coin
    // that landed on the accepting edge
    always_ff @(posedge clock) begin
        if (accept) begin
            price <= request.price;
        end
        if (dispensed) begin
            change_amount <= credit - price;
        end
    end

endmodule

`default_nettype wire

// File: src/change_dispenser.sv
/*
 * Change payout, one coin code per cycle, largest coin first.
 * The first coin shows in the cycle after change_load and the rest follow
 * without gaps. change_done pulses for one cycle after the last coin, or
 * right after the load when there is no change.
 */
`timescale 1ns/1ps
`default_nettype none

module change_dispenser (
    input  wire                            clock,
    input  wire                            reset,
    input  wire                            change_load,
    input  wire  [vend_pkg::CENTS_W-1:0]   change_amount,
    output logic [vend_pkg::COIN_W-1:0]    coin_return,
    output logic                           change_done
);

    logic                         busy;
    logic                         active;
    logic [vend_pkg::CENTS_W-1:0] remainder;
    logic [vend_pkg::CENTS_W-1:0] source;
    logic [vend_pkg::CENTS_W-1:0] pick_value;
    logic [vend_pkg::COIN_W-1:0]  pick_code;

    assign active = change_load || busy;
    assign source = change_load ? change_amount : remainder;   // Load pays at once

    // Table is ascending, so the last fit is the largest
    always_comb begin
        pick_code  = '0;
        pick_value = '0;
        for (int i = 1; i <= vend_pkg::NUM_COINS; i++) begin
            if (vend_pkg::COIN_VALUE[i] <= source) begin
                pick_code  = i[vend_pkg::COIN_W-1:0];
                pick_value = vend_pkg::COIN_VALUE[i];
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy        <= 1'b0;
            coin_return <= '0;
            change_done <= 1'b0;
        end else if (active && source != '0) begin
            busy        <= 1'b1;
            coin_return <= pick_code;
            change_done <= 1'b0;
        end else begin
            busy        <= 1'b0;
            coin_return <= '0;
            change_done <= active;              // Nothing left to pay
        end
    end

    always_ff @(posedge clock) begin
        if (active) begin
            remainder <= source - pick_value;
        end
    end

endmodule

`default_nettype wire

// File: src/vending_machine.sv
/*
 * Top level of the vending machine controller.
 * Connects the coin accumulator, keypad decoder, FSM and change
 * dispenser. credit drives the binary display, food_selection the
 * dispense motor and coin_return the coin hopper.
 */
`timescale 1ns/1ps
`default_nettype none

module vending_machine (
    input  wire                            clock,
    input  wire                            reset,
    input  wire  [vend_pkg::COIN_W-1:0]    coin,
    input  wire  vend_pkg::keypad_t        keypad,
    input  wire                            food_dispensed,
    output logic [vend_pkg::CENTS_W-1:0]   credit,
    output logic [vend_pkg::ITEM_W-1:0]    food_selection,
    output logic [vend_pkg::COIN_W-1:0]    coin_return
);

    vend_pkg::vend_request_t      request;
    logic                         coin_enable;
    logic                         credit_clear;
    logic                         change_load;
    logic                         change_done;
    logic [vend_pkg::CENTS_W-1:0] change_amount;

    coin_accumulator u_accumulator (
        .clock        (clock),
        .reset        (reset),
        .coin         (coin),
        .coin_enable  (coin_enable),
        .credit_clear (credit_clear),
        .credit       (credit)
    );

    keypad_decoder u_decoder (
        .keypad  (keypad),
        .request (request)
    );

    vend_controller u_controller (
        .clock          (clock),
        .reset          (reset),
        .request        (request),
        .credit         (credit),
        .food_dispensed (food_dispensed),
        .change_done    (change_done),
        .coin_enable    (coin_enable),
        .credit_clear   (credit_clear),
        .change_load    (change_load),
        .change_amount  (change_amount),
        .food_selection (food_selection)
    );

    change_dispenser u_dispenser (
        .clock         (clock),
        .reset         (reset),
        .change_load   (change_load),
        .change_amount (change_amount),
        .coin_return   (coin_return),
        .change_done   (change_done)
    );

endmodule

`default_nettype wire

// File: test/vending_machine_sva.sv
/*
 * Concurrent assertions for the vending machine top level.
 * Bound into vending_machine, they watch the FSM state, the item and
 * coin outputs and the dispenser's done strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module vending_machine_sva (
    input  wire                            clock,
    input  wire                            reset,
    input  wire  vend_pkg::vend_state_t    state,
    input  wire  [vend_pkg::ITEM_W-1:0]    food_selection,
    input  wire  [vend_pkg::COIN_W-1:0]    coin_return,
    input  wire  [vend_pkg::CENTS_W-1:0]   credit,
    input  wire                            change_done
);

    coin_only_returning: assert property (@(posedge clock) disable iff (reset)
        coin_return != '0 |-> state == vend_pkg::RETURNING)
        else $error("coin_return is nonzero outside RETURNING");

    item_shown_while_vending: assert property (@(posedge clock) disable iff (reset)
        state == vend_pkg::VENDING |-> food_selection != '0)
        else $error("food_selection is zero during VENDING");

    // First VENDING cycle is exempt since the item has just been latched
    item_stable_while_vending: assert property (@(posedge clock) disable iff (reset)
        (state == vend_pkg::VENDING && $past(state) == vend_pkg::VENDING)
        |-> $stable(food_selection))
        else $error("food_selection changed during VENDING");

    done_without_coin: assert property (@(posedge clock) disable iff (reset)
        change_done |-> coin_return == '0)
        else $error("change_done coincides with a returned coin");

    outputs_clear_after_reset: assert property (@(posedge clock)
        $fell(reset) |=> (credit == '0 && food_selection == '0 && coin_return == '0))
        else $error("outputs not zero in the first cycle after reset");

endmodule

bind vending_machine vending_machine_sva u_sva (
    .clock          (clock),
    .reset          (reset),
    .state          (u_controller.state),
    .food_selection (food_selection),
    .coin_return    (coin_return),
    .credit         (credit),
    .change_done    (change_done)
);

`default_nettype wire

// File: test/vending_machine_tb.sv
/*
 * Testbench for the vending machine controller.
 * Drives coins, key presses and the pressure sensor on the falling edge,
 * keeps its own credit model and checks each payout against a greedy
 * reference list. Ends with the check and error counts and a verdict.
 */
`timescale 1ns/1ps
`default_nettype none

module vending_machine_tb;

    localparam int CLOCK_PERIOD     = 4;
    localparam int RESET_CYCLES     = 8;
    localparam int NUM_RANDOM_VENDS = 10;
    localparam int NUM_TXNS         = NUM_RANDOM_VENDS + 5;
    localparam int MAX_TXN_CYCLES   = 120;
    localparam int MARGIN_CYCLES    = 50;
    localparam int WATCHDOG_CYCLES  = NUM_TXNS * MAX_TXN_CYCLES + MARGIN_CYCLES;
    localparam int PAYOUT_TIMEOUT   = 40;

    localparam int COIN_CENTS [0:6] = '{0, 1, 5, 10, 25, 50, 100};
    localparam int ROW_CENTS  [0:3] = '{100, 125, 150, 175};

    logic                         clock = 1'b0;
    logic                         reset;
    logic [vend_pkg::COIN_W-1:0]  coin;
    vend_pkg::keypad_t            keypad;
    logic                         food_dispensed;
    logic [vend_pkg::CENTS_W-1:0] credit;
    logic [vend_pkg::ITEM_W-1:0]  food_selection;
    logic [vend_pkg::COIN_W-1:0]  coin_return;

    integer seed             = 32'hc04d;
    int     errors           = 0;
    int     checks           = 0;
    int     monitor_errors   = 0;
    int     monitor_checks   = 0;
    int     model_credit     = 0;
    int     cycle_count      = 0;
    int     payout_count     = 0;
    int     payouts_expected = 0;
    string  current_test     = "reset";
    int     expected_coins [$];
    int     got_coins [$];
    int     got_cycles [$];

    vending_machine DUT (
        .clock          (clock),
        .reset          (reset),
        .coin           (coin),
        .keypad         (keypad),
        .food_dispensed (food_dispensed),
        .credit         (credit),
        .food_selection (food_selection),
        .coin_return    (coin_return)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference and helpers
    //////////////////////////////////////////////////////////////////////

    // Largest coin first until nothing is left
    function automatic void greedy_change(input int amount);
        int left;
        left = amount;
        expected_coins.delete();
        for (int code = 6; code >= 1; code--) begin
            while (left >= COIN_CENTS[code]) begin
                expected_coins.push_back(code);
                left -= COIN_CENTS[code];
            end
        end
    endfunction

    function automatic int random_code(input int low);
        return low + int'($unsigned($random(seed)) % (7 - low));
    endfunction

    task automatic check_equal(input string what, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("Mismatch in %s, %s: expected %0d, actual %0d",
                     current_test, what, expected, actual);
        end
    endtask

    task automatic insert_coin(input int code, input bit counted);
        @(negedge clock);
        coin = code[vend_pkg::COIN_W-1:0];
        @(negedge clock);
        coin = '0;
        if (counted) begin
            model_credit += COIN_CENTS[code];
        end
    endtask

    task automatic press_key(input int row_mask, input int col_mask);
        @(negedge clock);
        keypad.row = row_mask[vend_pkg::NUM_ROWS-1:0];
        keypad.col = col_mask[vend_pkg::NUM_COLS-1:0];
        @(negedge clock);
        keypad = '0;
    endtask

    task automatic check_ignored(input string what);
        repeat (2) begin
            check_equal({what, ", food_selection"}, 0, int'(food_selection));
            check_equal({what, ", credit"}, model_credit, int'(credit));
            @(negedge clock);
        end
    endtask

    task automatic top_up(input int price);
        int tries;
        tries = 0;
        while (model_credit < price) begin
            insert_coin(tries < 12 ? random_code(1) : 6, 1'b1);
            tries++;
        end
        check_equal("credit after coins", model_credit, int'(credit));
    endtask

    task automatic wait_for_payout();
        int waited;
        waited = 0;
        while (payout_count < payouts_expected && waited < PAYOUT_TIMEOUT) begin
            @(posedge clock);
            waited++;
        end
        @(negedge clock);
        if (payout_count < payouts_expected) begin
            errors++;
            $display("Change return in %s did not finish within %0d cycles",
                     current_test, PAYOUT_TIMEOUT);
        end
    endtask

    task automatic vend(input int row, input int col);
        int price;
        int item;
        int hold;
        price = ROW_CENTS[row];
        item  = row * 5 + col + 1;
        check_equal("credit before selection", model_credit, int'(credit));
        press_key(1 << row, 1 << col);
        check_equal("food_selection after accept", item, int'(food_selection));
        hold = 1 + int'($unsigned($random(seed)) % 4);
        repeat (hold) begin
            insert_coin(random_code(1), 1'b0);      // Must be ignored
            check_equal("food_selection while vending", item, int'(food_selection));
            check_equal("credit while vending", model_credit, int'(credit));
        end
        greedy_change(model_credit - price);
        payouts_expected++;
        @(negedge clock);
        food_dispensed = 1'b1;
        @(negedge clock);
        food_dispensed = 1'b0;
        check_equal("food_selection after dispense", 0, int'(food_selection));
        wait_for_payout();
        check_equal("credit after change", 0, int'(credit));
        model_credit = 0;
        @(negedge clock);                           // Back in COLLECTING
    endtask

    //////////////////////////////////////////////////////////////////////
    // Change monitor
    //////////////////////////////////////////////////////////////////////

    task automatic compare_payout();
        int first;
        first = cycle_count - got_coins.size();     // Coins end right before done
        monitor_checks++;
        if (got_coins.size() != expected_coins.size()) begin
            monitor_errors++;
            $display("Mismatch in %s, change coin count: expected %0d, actual %0d",
                     current_test, expected_coins.size(), got_coins.size());
        end
        for (int i = 0; i < got_coins.size(); i++) begin
            monitor_checks++;
            if (i < expected_coins.size() && got_coins[i] != expected_coins[i]) begin
                monitor_errors++;
                $display("Mismatch in %s, change coin %0d: expected %0d, actual %0d",
                         current_test, i, expected_coins[i], got_coins[i]);
            end
            if (got_cycles[i] != first + i) begin
                monitor_errors++;
                $display("Change coin %0d in %s came with a gap before change_done",
                         i, current_test);
            end
        end
        got_coins.delete();
        got_cycles.delete();
    endtask

    always @(negedge clock) begin
        if (!reset) begin
            if (coin_return != '0) begin
                got_coins.push_back(int'(coin_return));
                got_cycles.push_back(cycle_count);
            end
            if (DUT.change_done) begin
                compare_payout();
                payout_count++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        int row;
        int col;
        reset          = 1'b1;
        coin           = '0;
        keypad         = '0;
        food_dispensed = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        check_equal("credit", 0, int'(credit));
        check_equal("food_selection", 0, int'(food_selection));
        check_equal("coin_return", 0, int'(coin_return));

        current_test = "insufficient_credit";
        press_key(1, 1);
        check_ignored("row A with no credit");
        insert_coin(5, 1'b1);
        insert_coin(4, 1'b1);
        press_key(1, 1);
        check_ignored("row A with 75 cents");
        insert_coin(5, 1'b1);
        press_key(8, 16);
        check_ignored("row D with 125 cents");
        vend(1, 2);                                 // Item 8 at exact price

        current_test = "coin_counting";
        repeat (10) begin
            insert_coin(random_code(0), 1'b1);
            check_equal("credit", model_credit, int'(credit));
        end
        top_up(ROW_CENTS[3]);
        vend(3, 0);

        current_test = "exact_price";
        insert_coin(6, 1'b1);
        insert_coin(5, 1'b1);
        insert_coin(4, 1'b1);
        vend(3, 4);                                 // Item 20 with no change

        current_test = "ambiguous_press";
        insert_coin(6, 1'b1);
        insert_coin(6, 1'b1);
        press_key(3, 1);
        check_ignored("two rows");
        press_key(4, 6);
        check_ignored("two columns");
        press_key(0, 1);
        check_ignored("no row");
        vend(2, 1);                                 // Item 12 with 50 cents back

        current_test = "random_vend";
        repeat (NUM_RANDOM_VENDS) begin
            row = int'($unsigned($random(seed)) % 4);
            col = int'($unsigned($random(seed)) % 5);
            press_key(1 << row, 1 << col);
            check_ignored("selection with no credit");
            top_up(ROW_CENTS[row]);
            if (random_code(0) > 3) begin
                insert_coin(random_code(1), 1'b1);  // Some change to return
            end
            vend(row, col);
        end

        $display("Checks: %0d, errors: %0d", checks + monitor_checks, errors + monitor_errors);
        if (errors + monitor_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", checks + monitor_checks,
                 errors + monitor_errors + 1);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
src/vend_pkg.sv
src/coin_accumulator.sv
src/keypad_decoder.sv
src/vend_controller.sv
src/change_dispenser.sv
src/vending_machine.sv
test/vending_machine_sva.sv
test/vending_machine_tb.sv

// File: Makefile
# Verilator build and run of the vending machine testbench

VERILATOR ?= verilator
TOP       ?= vending_machine_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TEST PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
